//--- bench/tb_axi_write_xbar.sv
`timescale 1ns/100ps

module tb_axi_write_xbar;

    localparam int nm = xbar_cfg_pkg::master_num;
    localparam int ns = xbar_cfg_pkg::slave_num;

    logic                 clk;
    logic                 reset;
    logic [nm-1:0]        m_awvalid;
    logic [nm-1:0]        m_awready;
    logic [nm-1:0]        m_wvalid;
    logic [nm-1:0]        m_wready;
    logic [nm-1:0]        m_wlast;
    logic [nm-1:0]        m_bvalid;
    logic [nm-1:0]        m_bready;
    logic [ns-1:0]        s_awvalid;
    logic [ns-1:0]        s_awready;
    logic [ns-1:0]        s_wvalid;
    logic [ns-1:0]        s_wready;
    logic [ns-1:0]        s_wlast;
    logic [ns-1:0]        s_bvalid;
    logic [ns-1:0]        s_bready;
    axi_pkg::id_t         m_awid [nm];
    axi_pkg::id_t         m_bid [nm];
    axi_pkg::ext_id_t     s_awid [ns];
    axi_pkg::ext_id_t     s_bid [ns];
    axi_pkg::addr_t       m_awaddr [nm];
    axi_pkg::addr_t       s_awaddr [ns];
    axi_pkg::len_t        m_awlen [nm];
    axi_pkg::len_t        s_awlen [ns];
    axi_pkg::data_t       m_wdata [nm];
    axi_pkg::data_t       s_wdata [ns];
    axi_pkg::strb_t       m_wstrb [nm];
    axi_pkg::strb_t       s_wstrb [ns];
    axi_pkg::resp_e       m_bresp [nm];
    axi_pkg::resp_e       s_bresp [ns];

    // per slave ids of accepted bursts still owed a response
    axi_pkg::ext_id_t     pend_id [ns][$];
    logic [31:0]          rng;
    string                test_name;
    int                   cycles = 0;
    int                   cycle_limit = 0;

    axi_write_xbar uut (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            fail_run($sformatf("timeout after %0d cycles in %0s, no handshake came", cycles,
                               test_name));
        end
    end

    task automatic fail_run(input string why);
        $display("%0s", why);
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped");
    endtask

    task automatic mismatch(input string what, input string exp, input string act);
        fail_run($sformatf("ERROR %0s %0s: expected %0s, actual %0s", test_name, what, exp, act));
    endtask

    task automatic check_addr(input string what, input axi_pkg::addr_t exp, act);
        if (exp !== act) mismatch(what, $sformatf("%h", exp), $sformatf("%h", act));
    endtask
    task automatic check_ext_id(input string what, input axi_pkg::ext_id_t exp, act);
        if (exp !== act) mismatch(what, $sformatf("%h", exp), $sformatf("%h", act));
    endtask
    task automatic check_id(input string what, input axi_pkg::id_t exp, act);
        if (exp !== act) mismatch(what, $sformatf("%h", exp), $sformatf("%h", act));
    endtask
    task automatic check_len(input string what, input axi_pkg::len_t exp, act);
        if (exp !== act) mismatch(what, $sformatf("%0d", exp), $sformatf("%0d", act));
    endtask
    task automatic check_data(input string what, input axi_pkg::data_t exp, act);
        if (exp !== act) mismatch(what, $sformatf("%h", exp), $sformatf("%h", act));
    endtask
    task automatic check_strb(input string what, input axi_pkg::strb_t exp, act);
        if (exp !== act) mismatch(what, $sformatf("%b", exp), $sformatf("%b", act));
    endtask
    task automatic check_resp(input string what, input axi_pkg::resp_e exp, act);
        if (exp !== act) mismatch(what, exp.name(), act.name());
    endtask
    task automatic check_master(input string what, input int exp, act);
        if (exp != act) mismatch(what, $sformatf("%0d", exp), $sformatf("%0d", act));
    endtask

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // index of the single high bit or -1 for none and -2 for several
    function automatic int port_of(input logic [ns-1:0] v);
        int idx;
        idx = -1;
        for (int i = 0; i < ns; i++) begin
            if (v[i]) begin
                idx = (idx == -1) ? i : -2;
            end
        end
        return idx;
    endfunction

    task automatic drive_aw(input int m, input axi_pkg::addr_t addr, input int id, beats);
        m_awvalid[m] = 1'b1;
        m_awaddr[m]  = addr;
        m_awid[m]    = axi_pkg::id_t'(id);
        m_awlen[m]   = axi_pkg::len_t'(beats - 1);
    endtask

    // waits for the handshake and checks what the slave sees
    task automatic accept_aw(input int m, input int slave);
        axi_pkg::ext_id_t ext;
        ext = axi_pkg::ext_id_t'(m * (1 << xbar_cfg_pkg::id_width) + int'(m_awid[m]));
        #1;
        while (!m_awready[m]) begin
            @(negedge clk);
            #1;
        end
        check_master("aw slave", slave, port_of(s_awvalid));
        check_addr("awaddr", m_awaddr[m], s_awaddr[slave]);
        check_ext_id("awid", ext, s_awid[slave]);
        check_len("awlen", m_awlen[m], s_awlen[slave]);
        pend_id[slave].push_back(ext);
        @(negedge clk);
        m_awvalid[m] = 1'b0;
    endtask

    task automatic load_beat(input int m, input logic last);
        rng = xorshift(rng);
        m_wvalid[m] = 1'b1;
        m_wdata[m]  = axi_pkg::data_t'(rng);
        m_wstrb[m]  = axi_pkg::strb_t'(rng >> 16);
        m_wlast[m]  = last;
    endtask

    // first beat shown while the route queue is still empty
    task automatic offer_early_w(input int m, input int beats);
        load_beat(m, beats == 1);
        #1;
        if (m_wready[m]) begin
            fail_run($sformatf("%0s: write data accepted before its write address", test_name));
        end
        check_master("early w slave", -1, port_of(s_wvalid));
        @(negedge clk);
    endtask

    task automatic data_phase(input int m, input int slave, input int beats);
        for (int b = 0; b < beats; b++) begin
            if (!m_wvalid[m]) begin
                load_beat(m, b == beats - 1);
            end
            #1;
            while (!m_wready[m]) begin
                @(negedge clk);
                #1;
            end
            check_master("w slave", slave, port_of(s_wvalid));
            check_data("wdata", m_wdata[m], s_wdata[slave]);
            check_strb("wstrb", m_wstrb[m], s_wstrb[slave]);
            check_master("wlast", int'(m_wlast[m]), int'(s_wlast[slave]));
            @(negedge clk);
            m_wvalid[m] = 1'b0;
        end
        m_wlast[m] = 1'b0;
    endtask

    // slave model answers the oldest burst and echoes its id
    task automatic resp_phase(input int slave);
        axi_pkg::ext_id_t ext;
        axi_pkg::resp_e   resp;
        int               master;
        ext    = pend_id[slave].pop_front();
        master = int'(ext) >> xbar_cfg_pkg::id_width;
        rng    = xorshift(rng);
        resp   = axi_pkg::resp_e'(rng[1:0]);
        s_bvalid[slave] = 1'b1;
        s_bid[slave]    = ext;
        s_bresp[slave]  = resp;
        #1;
        while (!s_bready[slave]) begin
            @(negedge clk);
            #1;
        end
        check_master("b master", master, port_of(m_bvalid));
        check_id("bid", axi_pkg::id_t'(ext), m_bid[master]);
        check_resp("bresp", resp, m_bresp[master]);
        @(negedge clk);
        s_bvalid[slave] = 1'b0;
    endtask

    task automatic solo_burst(input int m, input axi_pkg::addr_t addr, input int id, beats, slave);
        offer_early_w(m, beats);
        drive_aw(m, addr, id, beats);
        accept_aw(m, slave);
        data_phase(m, slave, beats);
        resp_phase(slave);
    endtask

    // m is expected to win first and the other master follows
    task automatic contended_bursts(input int m, input axi_pkg::addr_t addr,
                                    input int id, beats, slave);
        int other;
        other = nm - 1 - m;
        drive_aw(m, addr, id, beats);
        drive_aw(other, addr ^ 16'h0040, id + 1, beats);
        #1;
        check_master("aw winner", m, port_of(m_awvalid & m_awready));
        accept_aw(m, slave);
        accept_aw(other, slave);
        data_phase(m, slave, beats);
        resp_phase(slave);
        data_phase(other, slave, beats);
        resp_phase(slave);
    endtask

    task automatic queue_limit_bursts(input int m, input axi_pkg::addr_t addr,
                                      input int id, beats, slave);
        for (int n = 0; n < xbar_cfg_pkg::w_queue_depth; n++) begin
            drive_aw(m, addr + axi_pkg::addr_t'(n * 256), id, beats);
            accept_aw(m, slave);
        end
        drive_aw(m, addr + 16'h0200, id, beats);
        repeat (3) begin
            #1;
            if (m_awready[m]) begin
                fail_run($sformatf("%0s: write address accepted with a full route queue",
                                   test_name));
            end
            @(negedge clk);
        end
        data_phase(m, slave, beats);
        accept_aw(m, slave);
        resp_phase(slave);
        repeat (2) begin
            data_phase(m, slave, beats);
            resp_phase(slave);
        end
    endtask

    initial begin
        string          lines[$];
        string          line;
        string          name;
        int             fd;
        int             m;
        int             id;
        int             beats;
        int             mode;
        int             slave;
        axi_pkg::addr_t addr;
        reset     = 1'b1;
        rng       = 32'd19945;
        test_name = "reset";
        m_awvalid = '0;
        m_wvalid  = '0;
        m_wlast   = '0;
        m_bready  = '1;
        s_awready = '1;
        s_wready  = '1;
        s_bvalid  = '0;
        m_awid    = '{default: '0};
        m_awaddr  = '{default: '0};
        m_awlen   = '{default: '0};
        m_wdata   = '{default: '0};
        m_wstrb   = '{default: '0};
        s_bid     = '{default: '0};
        s_bresp   = '{default: axi_pkg::okay};
        fd = $fopen("bench/xbar_cases.txt", "r");
        if (fd == 0) begin
            fail_run("cannot open bench/xbar_cases.txt");
        end
        while ($fgets(line, fd) != 0) begin
            // skip blank and comment lines
            if (line.len() > 1 && line[0] != "#") begin
                lines.push_back(line);
            end
        end
        $fclose(fd);
        cycle_limit = 40 * lines.size() + 20;
        repeat (5) @(negedge clk);
        reset = 1'b0;
        foreach (lines[i]) begin
            if ($sscanf(lines[i], "%s %d %h %d %d %d %d",
                        name, m, addr, id, beats, mode, slave) != 7) begin
                fail_run($sformatf("malformed case line: %0s", lines[i]));
            end
            test_name = name;
            case (mode)
                0: solo_burst(m, addr, id, beats, slave);
                1: contended_bursts(m, addr, id, beats, slave);
                2: queue_limit_bursts(m, addr, id, beats, slave);
                default: fail_run($sformatf("unknown mode %0d in case %0s", mode, name));
            endcase
        end
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

//--- bench/xbar_cases.txt
# columns: name, master, address (hex), id, beats, mode, expected slave
# mode 0 alone, 1 with a competing master, 2 route queue filled to its limit
aw_contend_reset   0 8010 1 2 1 1
aw_contend_again   0 0020 2 3 1 0
m0_to_s0           0 0100 0 1 0 0
m0_to_s1           0 8100 3 4 0 1
m0_bit15_low       0 7ffe 3 1 0 0
m1_to_s0           1 1234 2 2 0 0
m1_to_s1           1 fff0 1 1 0 1
m1_top_bit_only    1 8000 3 2 0 1
m0_queue_limit     0 8400 2 2 2 1
m1_queue_limit     1 0400 3 1 2 0
m1_long_burst      1 c000 0 8 0 1
aw_contend_late    0 4000 1 2 1 0

//--- hdl/arb_if.sv
`timescale 1ns/100ps

interface arb_if #(
    parameter axi_pkg::arb_chan_e chan      = axi_pkg::aw_chan,
    parameter int                 senders   = xbar_cfg_pkg::master_num,
    parameter int                 receivers = xbar_cfg_pkg::slave_num
);

    // one-hot wanted receiver per sender
    logic [senders-1:0][receivers-1:0] req;
    logic [senders-1:0][receivers-1:0] grant;
    logic [senders-1:0]                fire;
    // fire closes the unit of work
    logic [senders-1:0]                last;

    modport arbiter (input req, input fire, input last, output grant);
    modport router (output req, output fire, output last, input grant);

endinterface

//--- hdl/aw_router.sv
`timescale 1ns/100ps

module aw_router (
    input  logic                                clk,
    input  logic                                reset,
    input  logic [xbar_cfg_pkg::master_num-1:0] m_awvalid,
    output logic [xbar_cfg_pkg::master_num-1:0] m_awready,
    input  axi_pkg::id_t                        m_awid   [xbar_cfg_pkg::master_num],
    input  axi_pkg::addr_t                      m_awaddr [xbar_cfg_pkg::master_num],
    input  axi_pkg::len_t                       m_awlen  [xbar_cfg_pkg::master_num],
    output logic [xbar_cfg_pkg::slave_num-1:0]  s_awvalid,
    input  logic [xbar_cfg_pkg::slave_num-1:0]  s_awready,
    output axi_pkg::ext_id_t                    s_awid   [xbar_cfg_pkg::slave_num],
    output axi_pkg::addr_t                      s_awaddr [xbar_cfg_pkg::slave_num],
    output axi_pkg::len_t                       s_awlen  [xbar_cfg_pkg::slave_num],
    arb_if.router                               aw_arb,
    input  logic [xbar_cfg_pkg::master_num-1:0] queue_full,
    output logic [xbar_cfg_pkg::slave_num-1:0]  aw_route [xbar_cfg_pkg::master_num],
    output logic [xbar_cfg_pkg::master_num-1:0] aw_push
);

    localparam int head_w = xbar_cfg_pkg::ext_id_width - xbar_cfg_pkg::id_width;

    logic [xbar_cfg_pkg::slave_num-1:0]  sel [xbar_cfg_pkg::master_num];
    axi_pkg::ext_id_t                    ext_id [xbar_cfg_pkg::master_num];
    logic [xbar_cfg_pkg::master_num-1:0] granted;
    // shown to a slave last cycle but not taken
    logic [xbar_cfg_pkg::master_num-1:0] stalled;
    logic [xbar_cfg_pkg::master_num-1:0] blocked;

    for (genvar m = 0; m < xbar_cfg_pkg::master_num; m++) begin : g_id
        assign ext_id[m] = {head_w'(m), m_awid[m]};
    end

    always_comb begin
        for (int m = 0; m < xbar_cfg_pkg::master_num; m++) begin
            sel[m] = '0;
            sel[m][m_awaddr[m][xbar_cfg_pkg::slave_sel_bit]] = 1'b1;
        end
        // keep a waiting aw on its slave until accepted
        for (int m = 0; m < xbar_cfg_pkg::master_num; m++) begin
            blocked[m] = 1'b0;
            for (int o = 0; o < xbar_cfg_pkg::master_num; o++) begin
                if (o != m && stalled[o] && sel[o] == sel[m]) begin
                    blocked[m] = 1'b1;
                end
            end
            aw_arb.req[m] = (m_awvalid[m] && !queue_full[m] && !blocked[m]) ? sel[m] : '0;
            granted[m]    = |aw_arb.grant[m];
            m_awready[m]  = |(aw_arb.grant[m] & s_awready);
        end
    end

    always_comb begin
        for (int r = 0; r < xbar_cfg_pkg::slave_num; r++) begin
            s_awvalid[r] = 1'b0;
            s_awid[r]    = '0;
            s_awaddr[r]  = '0;
            s_awlen[r]   = '0;
            for (int m = 0; m < xbar_cfg_pkg::master_num; m++) begin
                if (aw_arb.grant[m][r]) begin
                    s_awvalid[r] = m_awvalid[m];
                    s_awid[r]    = ext_id[m];
                    s_awaddr[r]  = m_awaddr[m];
                    s_awlen[r]   = m_awlen[m];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            stalled <= '0;
        end else begin
            stalled <= m_awvalid & granted & ~m_awready;
        end
    end

    assign aw_arb.fire = m_awvalid & m_awready;
    assign aw_arb.last = aw_arb.fire;
    assign aw_push     = aw_arb.fire;
    assign aw_route    = sel;

endmodule

//--- hdl/axi_pkg.sv
package axi_pkg;

    typedef logic [xbar_cfg_pkg::addr_width-1:0]   addr_t;
    typedef logic [xbar_cfg_pkg::data_width-1:0]   data_t;
    typedef logic [xbar_cfg_pkg::data_width/8-1:0] strb_t;
    typedef logic [xbar_cfg_pkg::id_width-1:0]     id_t;
    typedef logic [xbar_cfg_pkg::ext_id_width-1:0] ext_id_t;
    typedef logic [7:0]                            len_t;

    typedef enum logic [1:0] {
        okay   = 2'b00,
        exokay = 2'b01,
        slverr = 2'b10,
        decerr = 2'b11
    } resp_e;

    // channel an arbitration port belongs to
    typedef enum logic [1:0] {
        aw_chan,
        w_chan,
        b_chan
    } arb_chan_e;

endpackage

//--- hdl/axi_write_xbar.sv
`timescale 1ns/100ps

module axi_write_xbar (
    input  logic                                clk,
    input  logic                                reset,
    // master side
    input  logic [xbar_cfg_pkg::master_num-1:0] m_awvalid,
    output logic [xbar_cfg_pkg::master_num-1:0] m_awready,
    input  axi_pkg::id_t                        m_awid   [xbar_cfg_pkg::master_num],
    input  axi_pkg::addr_t                      m_awaddr [xbar_cfg_pkg::master_num],
    input  axi_pkg::len_t                       m_awlen  [xbar_cfg_pkg::master_num],
    input  logic [xbar_cfg_pkg::master_num-1:0] m_wvalid,
    output logic [xbar_cfg_pkg::master_num-1:0] m_wready,
    input  axi_pkg::data_t                      m_wdata  [xbar_cfg_pkg::master_num],
    input  axi_pkg::strb_t                      m_wstrb  [xbar_cfg_pkg::master_num],
    input  logic [xbar_cfg_pkg::master_num-1:0] m_wlast,
    output logic [xbar_cfg_pkg::master_num-1:0] m_bvalid,
    input  logic [xbar_cfg_pkg::master_num-1:0] m_bready,
    output axi_pkg::id_t                        m_bid    [xbar_cfg_pkg::master_num],
    output axi_pkg::resp_e                      m_bresp  [xbar_cfg_pkg::master_num],
    // slave side
    output logic [xbar_cfg_pkg::slave_num-1:0]  s_awvalid,
    input  logic [xbar_cfg_pkg::slave_num-1:0]  s_awready,
    output axi_pkg::ext_id_t                    s_awid   [xbar_cfg_pkg::slave_num],
    output axi_pkg::addr_t                      s_awaddr [xbar_cfg_pkg::slave_num],
    output axi_pkg::len_t                       s_awlen  [xbar_cfg_pkg::slave_num],
    output logic [xbar_cfg_pkg::slave_num-1:0]  s_wvalid,
    input  logic [xbar_cfg_pkg::slave_num-1:0]  s_wready,
    output axi_pkg::data_t                      s_wdata  [xbar_cfg_pkg::slave_num],
    output axi_pkg::strb_t                      s_wstrb  [xbar_cfg_pkg::slave_num],
    output logic [xbar_cfg_pkg::slave_num-1:0]  s_wlast,
    input  logic [xbar_cfg_pkg::slave_num-1:0]  s_bvalid,
    output logic [xbar_cfg_pkg::slave_num-1:0]  s_bready,
    input  axi_pkg::ext_id_t                    s_bid    [xbar_cfg_pkg::slave_num],
    input  axi_pkg::resp_e                      s_bresp  [xbar_cfg_pkg::slave_num]
);

    logic [xbar_cfg_pkg::slave_num-1:0]  aw_route [xbar_cfg_pkg::master_num];
    logic [xbar_cfg_pkg::master_num-1:0] aw_push;
    logic [xbar_cfg_pkg::master_num-1:0] queue_full;

    arb_if #(.chan(axi_pkg::aw_chan), .senders(xbar_cfg_pkg::master_num),
             .receivers(xbar_cfg_pkg::slave_num)) aw_arb ();
    arb_if #(.chan(axi_pkg::w_chan), .senders(xbar_cfg_pkg::master_num),
             .receivers(xbar_cfg_pkg::slave_num)) w_arb ();
    // responses flow slave to master
    arb_if #(.chan(axi_pkg::b_chan), .senders(xbar_cfg_pkg::slave_num),
             .receivers(xbar_cfg_pkg::master_num)) b_arb ();

    write_arbiter arb (.clk(clk), .reset(reset), .aw_arb(aw_arb), .w_arb(w_arb), .b_arb(b_arb));

    aw_router aw_rt (
        .clk(clk), .reset(reset),
        .m_awvalid(m_awvalid), .m_awready(m_awready), .m_awid(m_awid),
        .m_awaddr(m_awaddr), .m_awlen(m_awlen),
        .s_awvalid(s_awvalid), .s_awready(s_awready), .s_awid(s_awid),
        .s_awaddr(s_awaddr), .s_awlen(s_awlen),
        .aw_arb(aw_arb), .queue_full(queue_full), .aw_route(aw_route), .aw_push(aw_push)
    );

    w_router w_rt (
        .clk(clk), .reset(reset),
        .m_wvalid(m_wvalid), .m_wready(m_wready), .m_wdata(m_wdata),
        .m_wstrb(m_wstrb), .m_wlast(m_wlast),
        .s_wvalid(s_wvalid), .s_wready(s_wready), .s_wdata(s_wdata),
        .s_wstrb(s_wstrb), .s_wlast(s_wlast),
        .w_arb(w_arb), .aw_route(aw_route), .aw_push(aw_push), .queue_full(queue_full)
    );

    b_router b_rt (
        .s_bvalid(s_bvalid), .s_bready(s_bready), .s_bid(s_bid), .s_bresp(s_bresp),
        .m_bvalid(m_bvalid), .m_bready(m_bready), .m_bid(m_bid), .m_bresp(m_bresp),
        .b_arb(b_arb)
    );

endmodule

//--- hdl/b_router.sv
`timescale 1ns/100ps

module b_router (
    input  logic [xbar_cfg_pkg::slave_num-1:0]  s_bvalid,
    output logic [xbar_cfg_pkg::slave_num-1:0]  s_bready,
    input  axi_pkg::ext_id_t                    s_bid   [xbar_cfg_pkg::slave_num],
    input  axi_pkg::resp_e                      s_bresp [xbar_cfg_pkg::slave_num],
    output logic [xbar_cfg_pkg::master_num-1:0] m_bvalid,
    input  logic [xbar_cfg_pkg::master_num-1:0] m_bready,
    output axi_pkg::id_t                        m_bid   [xbar_cfg_pkg::master_num],
    output axi_pkg::resp_e                      m_bresp [xbar_cfg_pkg::master_num],
    arb_if.router                               b_arb
);

    localparam int head_w = xbar_cfg_pkg::ext_id_width - xbar_cfg_pkg::id_width;

    logic [head_w-1:0] head   [xbar_cfg_pkg::slave_num];
    axi_pkg::id_t      low_id [xbar_cfg_pkg::slave_num];

    always_comb begin
        for (int r = 0; r < xbar_cfg_pkg::slave_num; r++) begin
            {head[r], low_id[r]} = s_bid[r];
            // head bits name the master that issued the write
            b_arb.req[r] = '0;
            if (s_bvalid[r]) begin
                b_arb.req[r][head[r]] = 1'b1;
            end
            s_bready[r] = |(b_arb.grant[r] & m_bready);
        end
    end

    always_comb begin
        for (int m = 0; m < xbar_cfg_pkg::master_num; m++) begin
            m_bvalid[m] = 1'b0;
            m_bid[m]    = '0;
            m_bresp[m]  = axi_pkg::okay;
            for (int r = 0; r < xbar_cfg_pkg::slave_num; r++) begin
                if (b_arb.grant[r][m]) begin
                    m_bvalid[m] = s_bvalid[r];
                    m_bid[m]    = low_id[r];
                    m_bresp[m]  = s_bresp[r];
                end
            end
        end
    end

    assign b_arb.fire = s_bvalid & s_bready;
    assign b_arb.last = b_arb.fire;

endmodule

//--- hdl/w_router.sv
`timescale 1ns/100ps

module w_router (
    input  logic                                clk,
    input  logic                                reset,
    input  logic [xbar_cfg_pkg::master_num-1:0] m_wvalid,
    output logic [xbar_cfg_pkg::master_num-1:0] m_wready,
    input  axi_pkg::data_t                      m_wdata [xbar_cfg_pkg::master_num],
    input  axi_pkg::strb_t                      m_wstrb [xbar_cfg_pkg::master_num],
    input  logic [xbar_cfg_pkg::master_num-1:0] m_wlast,
    output logic [xbar_cfg_pkg::slave_num-1:0]  s_wvalid,
    input  logic [xbar_cfg_pkg::slave_num-1:0]  s_wready,
    output axi_pkg::data_t                      s_wdata [xbar_cfg_pkg::slave_num],
    output axi_pkg::strb_t                      s_wstrb [xbar_cfg_pkg::slave_num],
    output logic [xbar_cfg_pkg::slave_num-1:0]  s_wlast,
    arb_if.router                               w_arb,
    input  logic [xbar_cfg_pkg::slave_num-1:0]  aw_route [xbar_cfg_pkg::master_num],
    input  logic [xbar_cfg_pkg::master_num-1:0] aw_push,
    output logic [xbar_cfg_pkg::master_num-1:0] queue_full
);

    localparam int depth = xbar_cfg_pkg::w_queue_depth;
    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
    localparam int cnt_w = $clog2(depth + 1);

    // route select per queued aw
    logic [xbar_cfg_pkg::slave_num-1:0]  queue [xbar_cfg_pkg::master_num][depth];
    logic [ptr_w-1:0]                    wr_ptr [xbar_cfg_pkg::master_num];
    logic [ptr_w-1:0]                    rd_ptr [xbar_cfg_pkg::master_num];
    logic [cnt_w-1:0]                    count  [xbar_cfg_pkg::master_num];
    logic [xbar_cfg_pkg::master_num-1:0] pop;

    function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
        return (ptr == ptr_w'(depth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int m = 0; m < xbar_cfg_pkg::master_num; m++) begin
                wr_ptr[m] <= '0;
                rd_ptr[m] <= '0;
                count[m]  <= '0;
            end
        end else begin
            for (int m = 0; m < xbar_cfg_pkg::master_num; m++) begin
                if (aw_push[m]) begin
                    wr_ptr[m] <= next_ptr(wr_ptr[m]);
                end
                if (pop[m]) begin
                    rd_ptr[m] <= next_ptr(rd_ptr[m]);
                end
                count[m] <= count[m] + cnt_w'(aw_push[m]) - cnt_w'(pop[m]);
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int m = 0; m < xbar_cfg_pkg::master_num; m++) begin
            if (aw_push[m]) begin
                queue[m][wr_ptr[m]] <= aw_route[m];
            end
        end
    end

    always_comb begin
        for (int m = 0; m < xbar_cfg_pkg::master_num; m++) begin
            queue_full[m] = (count[m] == cnt_w'(depth));
            // head entry steers the beats, nothing while empty
            w_arb.req[m]  = (m_wvalid[m] && count[m] != '0) ? queue[m][rd_ptr[m]] : '0;
            m_wready[m]   = |(w_arb.grant[m] & s_wready);
        end
    end

    always_comb begin
        for (int r = 0; r < xbar_cfg_pkg::slave_num; r++) begin
            s_wvalid[r] = 1'b0;
            s_wdata[r]  = '0;
            s_wstrb[r]  = '0;
            s_wlast[r]  = 1'b0;
            for (int m = 0; m < xbar_cfg_pkg::master_num; m++) begin
                if (w_arb.grant[m][r]) begin
                    s_wvalid[r] = m_wvalid[m];
                    s_wdata[r]  = m_wdata[m];
                    s_wstrb[r]  = m_wstrb[m];
                    s_wlast[r]  = m_wlast[m];
                end
            end
        end
    end

    assign w_arb.fire = m_wvalid & m_wready;
    assign w_arb.last = w_arb.fire & m_wlast;
    assign pop        = w_arb.last;

endmodule

//--- hdl/write_arbiter.sv
`timescale 1ns/100ps

module write_arbiter (
    input logic    clk,
    input logic    reset,
    arb_if.arbiter aw_arb,
    arb_if.arbiter w_arb,
    arb_if.arbiter b_arb
);

    // square crossbar, one count for senders and receivers
    localparam int n     = xbar_cfg_pkg::master_num;
    localparam int sel_w = (n > 1) ? $clog2(n) : 1;
    localparam logic [sel_w-1:0] low_init = sel_w'(n - 1);

    // lowest priority sender per channel
    logic [sel_w-1:0] aw_low;
    logic [sel_w-1:0] w_low;
    logic [sel_w-1:0] b_low;
    // w burst in flight per sender
    logic [n-1:0]     w_open;

    function automatic logic [n-1:0][n-1:0] pick(
        input axi_pkg::arb_chan_e     chan,
        input logic [n-1:0][n-1:0]    req,
        input logic [sel_w-1:0]       low,
        input logic [n-1:0]           open
    );
        logic [n-1:0][n-1:0] grant;
        int                  s;
        grant = '0;
        for (int r = 0; r < n; r++) begin
            logic done;
            done = 1'b0;
            // an open w burst keeps its receiver
            if (chan == axi_pkg::w_chan) begin
                for (int k = 0; k < n; k++) begin
                    if (open[k] && req[k][r]) begin
                        grant[k][r] = 1'b1;
                        done = 1'b1;
                    end
                end
            end
            for (int k = 1; k <= n; k++) begin
                s = (int'(low) + k) % n;
                if (!done && req[s][r]) begin
                    grant[s][r] = 1'b1;
                    done = 1'b1;
                end
            end
        end
        return grant;
    endfunction

    function automatic logic [sel_w-1:0] next_low(
        input logic [n-1:0]     fire,
        input logic [n-1:0]     last,
        input logic [sel_w-1:0] low
    );
        logic [sel_w-1:0] res;
        res = low;
        for (int s = 0; s < n; s++) begin
            if (fire[s] && last[s]) begin
                res = sel_w'(s);
            end
        end
        return res;
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            aw_low <= low_init;
            w_low  <= low_init;
            b_low  <= low_init;
            w_open <= '0;
        end else begin
            aw_low <= next_low(aw_arb.fire, aw_arb.last, aw_low);
            w_low  <= next_low(w_arb.fire, w_arb.last, w_low);
            b_low  <= next_low(b_arb.fire, b_arb.last, b_low);
            w_open <= (w_open | w_arb.fire) & ~(w_arb.fire & w_arb.last);
        end
    end

    // hold flags only take effect on w
    assign aw_arb.grant = pick(aw_arb.chan, aw_arb.req, aw_low, w_open);
    assign w_arb.grant  = pick(w_arb.chan, w_arb.req, w_low, w_open);
    assign b_arb.grant  = pick(b_arb.chan, b_arb.req, b_low, w_open);

endmodule

//--- hdl/xbar_cfg_pkg.sv
package xbar_cfg_pkg;

    // port counts
    localparam int master_num = 2;
    localparam int slave_num  = 2;

    localparam int addr_width = 16;
    localparam int data_width = 16;
    localparam int id_width   = 2;

    // slave side id carries the master index on top
    localparam int ext_id_width = id_width + $clog2(master_num);

    // outstanding aw per master awaiting w
    localparam int w_queue_depth = 2;

    localparam int slave_sel_bit = 15;

endpackage

//--- project.f
hdl/xbar_cfg_pkg.sv
hdl/axi_pkg.sv
hdl/arb_if.sv
hdl/write_arbiter.sv
hdl/aw_router.sv
hdl/w_router.sv
hdl/b_router.sv
hdl/axi_write_xbar.sv
bench/tb_axi_write_xbar.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --timescale 1ns/100ps -f project.f --top-module tb_axi_write_xbar
./obj_dir/Vtb_axi_write_xbar
